//--- ipod_pkg.sv
package ipod_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int SAMPLE_W  = 16;
  localparam int WORD_W    = 2 * SAMPLE_W;
  localparam int ADDR_W    = 23;
  localparam int DIVISOR_W = 24;
  localparam int SEG_W     = 7;

  // One audio sample, two of them per flash word
  typedef logic [SAMPLE_W-1:0]  sample_t;
  typedef logic [WORD_W-1:0]    flash_word_t;
  typedef logic [ADDR_W-1:0]    flash_addr_t;

  // Clock cycles per sample, six hex digits on the display
  typedef logic [DIVISOR_W-1:0] divisor_t;

  // Active low, segment a in bit 0
  typedef logic [SEG_W-1:0]     seg_t;

  // ========================================
  // Keyboard commands, values are ASCII
  // ========================================
  typedef enum logic [7:0] {
    cmd_play     = 8'h45,
    cmd_pause    = 8'h44,
    cmd_forward  = 8'h46,
    cmd_backward = 8'h42,
    cmd_restart  = 8'h52
  } cmd_t;

  // Flash reader FSM
  typedef enum logic [1:0] {
    idle,
    request,
    wait_data,
    hold
  } reader_state_t;

endpackage

//--- key_command_decoder.sv
module key_command_decoder (
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic [7:0] ascii_code,
  input  logic       ascii_strobe,
  output logic       paused,
  output logic       backward,
  output logic       restart
);
  import ipod_pkg::*;

  logic [7:0] code_upper;
  cmd_t       cmd;

  // Fold lower case letters onto upper case
  always_comb
  begin
    if (ascii_code >= 8'h61 && ascii_code <= 8'h7A)
      code_upper = ascii_code - 8'h20;
    else
      code_upper = ascii_code;
  end

  assign cmd = cmd_t'(code_upper);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      paused   <= 1'b1;
      backward <= 1'b0;
      restart  <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (ascii_strobe)
      begin
        case (cmd)
          cmd_play:     paused   <= 1'b0;
          cmd_pause:    paused   <= 1'b1;
          cmd_forward:  backward <= 1'b0;
          cmd_backward: backward <= 1'b1;
          cmd_restart:  restart  <= 1'b1;
          // Anything else is ignored
          default: ;
        endcase
      end
    end
  end

endmodule

//--- speed_control.sv
module speed_control #(
  parameter int unsigned DEFAULT_DIVISOR = 1136,
  parameter int unsigned DIVISOR_STEP    = 100,
  parameter int unsigned MIN_DIVISOR     = 200,
  parameter int unsigned MAX_DIVISOR     = 50000,
  parameter int unsigned REPEAT_CYCLES   = 5000000
) (
  input  logic               CLK_50M,
  input  logic               rst,
  input  logic               speed_up_key,
  input  logic               speed_down_key,
  input  logic               speed_reset_key,
  output ipod_pkg::divisor_t divisor
);
  import ipod_pkg::*;

  localparam int CNT_W = $clog2(REPEAT_CYCLES + 1);
  localparam logic [CNT_W-1:0] REPEAT_LAST = CNT_W'(REPEAT_CYCLES - 1);

  logic             up_q;
  logic             down_q;
  logic [CNT_W-1:0] repeat_cnt;
  logic             repeat_due;
  logic             step_up;
  logic             step_down;
  divisor_t         div_faster;
  divisor_t         div_slower;

  assign repeat_due = (repeat_cnt == REPEAT_LAST);

  // Step on a rising edge, then again each time the repeat count runs out
  // Up has priority when both keys are held
  assign step_up   = speed_up_key && (!up_q || repeat_due);
  assign step_down = !speed_up_key && speed_down_key && (!down_q || repeat_due);

  // Clamped next values
  assign div_faster = (divisor < divisor_t'(MIN_DIVISOR + DIVISOR_STEP)) ?
                      divisor_t'(MIN_DIVISOR) : divisor - divisor_t'(DIVISOR_STEP);
  assign div_slower = (divisor > divisor_t'(MAX_DIVISOR - DIVISOR_STEP)) ?
                      divisor_t'(MAX_DIVISOR) : divisor + divisor_t'(DIVISOR_STEP);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      up_q       <= 1'b0;
      down_q     <= 1'b0;
      repeat_cnt <= '0;
      divisor    <= divisor_t'(DEFAULT_DIVISOR);
    end
    else
    begin
      up_q   <= speed_up_key;
      down_q <= speed_down_key;

      if (step_up || step_down || speed_reset_key)
        repeat_cnt <= '0;
      else if (!repeat_due)
        repeat_cnt <= repeat_cnt + 1'b1;

      if (speed_reset_key)
        divisor <= divisor_t'(DEFAULT_DIVISOR);
      else if (step_up)
        divisor <= div_faster;
      else if (step_down)
        divisor <= div_slower;
    end
  end

endmodule

//--- sample_tick_gen.sv
module sample_tick_gen (
  input  logic               CLK_50M,
  input  logic               rst,
  input  ipod_pkg::divisor_t divisor,
  output logic               sample_tick
);
  import ipod_pkg::*;

  divisor_t count;
  // Period in use, picked up from divisor at each restart
  divisor_t period;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count       <= '0;
      period      <= divisor;
      sample_tick <= 1'b0;
    end
    else if (count == period - 1'b1)
    begin
      count       <= '0;
      period      <= divisor;
      sample_tick <= 1'b1;
    end
    else
    begin
      count       <= count + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

//--- flash_sample_reader.sv
module flash_sample_reader #(
  parameter ipod_pkg::flash_addr_t LAST_WORD_ADDR = 23'h07FFFF
) (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  sample_tick,
  input  logic                  paused,
  input  logic                  backward,
  input  logic                  restart,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_valid
);
  import ipod_pkg::*;

  reader_state_t state;
  sample_t       held_half;
  logic          restart_pending;
  logic          play_tick;
  sample_t       word_hi;
  sample_t       word_lo;
  flash_addr_t   start_addr;
  flash_addr_t   next_addr;

  assign play_tick  = sample_tick && !paused;
  assign word_hi    = flash_readdata[WORD_W-1:SAMPLE_W];
  assign word_lo    = flash_readdata[SAMPLE_W-1:0];
  assign start_addr = backward ? LAST_WORD_ADDR : '0;

  // Address step with wrap at both ends
  always_comb
  begin
    if (backward)
      next_addr = (flash_address == '0) ? LAST_WORD_ADDR : flash_address - 1'b1;
    else
      next_addr = (flash_address == LAST_WORD_ADDR) ? '0 : flash_address + 1'b1;
  end

  // ========================================
  // Fetch and playback FSM
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state           <= idle;
      flash_read      <= 1'b0;
      flash_address   <= '0;
      audio_sample    <= '0;
      sample_valid    <= 1'b0;
      restart_pending <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        idle:
        begin
          if (restart)
            flash_address <= start_addr;
          else if (play_tick)
          begin
            flash_read <= 1'b1;
            state      <= request;
          end
        end
        request:
        begin
          // Address must stay put until accepted, so restart waits
          if (restart)
            restart_pending <= 1'b1;
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= wait_data;
          end
        end
        wait_data:
        begin
          if (flash_readdatavalid)
          begin
            restart_pending <= 1'b0;
            state           <= idle;
            if (restart || restart_pending)
              flash_address <= start_addr;
            else if (!paused)
            begin
              // Forward plays low half first, backward high half first
              audio_sample  <= backward ? word_hi : word_lo;
              held_half     <= backward ? word_lo : word_hi;
              sample_valid  <= 1'b1;
              flash_address <= next_addr;
              state         <= hold;
            end
            // Paused mid-fetch: word dropped, same address fetched again later
          end
          else if (restart)
            restart_pending <= 1'b1;
        end
        hold:
        begin
          if (restart)
          begin
            flash_address <= start_addr;
            state         <= idle;
          end
          else if (play_tick)
          begin
            audio_sample <= held_half;
            sample_valid <= 1'b1;
            state        <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

//--- hex_display.sv
module hex_display (
  input  ipod_pkg::divisor_t divisor,
  output ipod_pkg::seg_t     hex0,
  output ipod_pkg::seg_t     hex1,
  output ipod_pkg::seg_t     hex2,
  output ipod_pkg::seg_t     hex3,
  output ipod_pkg::seg_t     hex4,
  output ipod_pkg::seg_t     hex5
);
  import ipod_pkg::*;

  // Bits are g..a, a zero lights the segment
  function automatic seg_t encode(input logic [3:0] nibble);
    seg_t seg;
    case (nibble)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // hex0 is the least significant digit
  assign hex0 = encode(divisor[3:0]);
  assign hex1 = encode(divisor[7:4]);
  assign hex2 = encode(divisor[11:8]);
  assign hex3 = encode(divisor[15:12]);
  assign hex4 = encode(divisor[19:16]);
  assign hex5 = encode(divisor[23:20]);

endmodule

//--- simple_ipod_top.sv
module simple_ipod_top #(
  parameter int unsigned           DEFAULT_DIVISOR = 1136,
  parameter int unsigned           DIVISOR_STEP    = 100,
  parameter int unsigned           MIN_DIVISOR     = 200,
  parameter int unsigned           MAX_DIVISOR     = 50000,
  parameter int unsigned           REPEAT_CYCLES   = 5000000,
  parameter ipod_pkg::flash_addr_t LAST_WORD_ADDR  = 23'h07FFFF
) (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic [7:0]            ascii_code,
  input  logic                  ascii_strobe,
  input  logic                  speed_up_key,
  input  logic                  speed_down_key,
  input  logic                  speed_reset_key,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_valid,
  output ipod_pkg::seg_t        hex0,
  output ipod_pkg::seg_t        hex1,
  output ipod_pkg::seg_t        hex2,
  output ipod_pkg::seg_t        hex3,
  output ipod_pkg::seg_t        hex4,
  output ipod_pkg::seg_t        hex5
);
  import ipod_pkg::*;

  logic     paused;
  logic     backward;
  logic     restart;
  logic     sample_tick;
  divisor_t divisor;

  // ========================================
  // Keyboard and speed
  // ========================================
  key_command_decoder u_keys (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .ascii_code   (ascii_code),
    .ascii_strobe (ascii_strobe),
    .paused       (paused),
    .backward     (backward),
    .restart      (restart)
  );

  speed_control #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR),
    .DIVISOR_STEP    (DIVISOR_STEP),
    .MIN_DIVISOR     (MIN_DIVISOR),
    .MAX_DIVISOR     (MAX_DIVISOR),
    .REPEAT_CYCLES   (REPEAT_CYCLES)
  ) u_speed (
    .CLK_50M         (CLK_50M),
    .rst             (rst),
    .speed_up_key    (speed_up_key),
    .speed_down_key  (speed_down_key),
    .speed_reset_key (speed_reset_key),
    .divisor         (divisor)
  );

  sample_tick_gen u_tick (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .divisor     (divisor),
    .sample_tick (sample_tick)
  );

  // ========================================
  // Playback and display
  // ========================================
  flash_sample_reader #(
    .LAST_WORD_ADDR (LAST_WORD_ADDR)
  ) u_reader (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .sample_tick         (sample_tick),
    .paused              (paused),
    .backward            (backward),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid)
  );

  hex_display u_hex (
    .divisor (divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

//--- flash_model.sv
module flash_model (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  flash_read,
  input  ipod_pkg::flash_addr_t flash_address,
  output logic                  flash_waitrequest,
  output ipod_pkg::flash_word_t flash_readdata,
  output logic                  flash_readdatavalid
);
  timeunit 1ns;
  timeprecision 1ps;
  import ipod_pkg::*;

  logic [31:0] rng;
  logic [31:0] rand_a;
  logic [31:0] rand_b;
  logic [1:0]  wait_left;
  logic [2:0]  latency_left;
  logic        busy;
  flash_addr_t read_addr;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  assign rand_a = xorshift(rng);
  assign rand_b = xorshift(rand_a);

  // ========================================
  // Wait request and read latency
  // ========================================
  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      rng                 <= 32'hdbe1;
      flash_waitrequest   <= 1'b1;
      wait_left           <= 2'd1;
      latency_left        <= 3'd0;
      busy                <= 1'b0;
      read_addr           <= '0;
      flash_readdata      <= '0;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      if (flash_read && !flash_waitrequest)
      begin
        // Accepted, so pick this latency and the stall of the next request
        read_addr         <= flash_address;
        busy              <= 1'b1;
        latency_left      <= {1'b0, rand_a[1:0]} + 3'd1;
        wait_left         <= rand_b[1:0];
        flash_waitrequest <= (rand_b[1:0] != 2'd0);
        rng               <= rand_b;
      end
      else if (flash_read && flash_waitrequest)
      begin
        if (wait_left == 2'd1)
          flash_waitrequest <= 1'b0;
        wait_left <= wait_left - 2'd1;
      end

      if (busy)
      begin
        if (latency_left == 3'd1)
        begin
          // High half is the address XOR 5A5Ah, low half the address
          flash_readdata      <= {read_addr[15:0] ^ 16'h5A5A, read_addr[15:0]};
          flash_readdatavalid <= 1'b1;
          busy                <= 1'b0;
        end
        else
          latency_left <= latency_left - 3'd1;
      end
    end
  end

endmodule

//--- tb_simple_ipod.sv
module tb_simple_ipod;
  timeunit 1ns;
  timeprecision 1ps;
  import ipod_pkg::*;

  localparam int unsigned DEFAULT_DIV = 200;
  localparam int unsigned DIV_STEP    = 10;
  localparam int unsigned MIN_DIV     = 120;
  localparam int unsigned MAX_DIV     = 400;
  localparam int unsigned REPEAT      = 40;
  localparam flash_addr_t LAST_ADDR   = 23'h00000F;
  localparam int          MAX_STEPS   = 64;
  localparam int unsigned MARGIN      = 2000;

  // Digits 0..F, active low with segment a in bit 0
  localparam seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic        CLK_50M;
  logic        rst;
  logic [7:0]  ascii_code;
  logic        ascii_strobe;
  logic        speed_up_key;
  logic        speed_down_key;
  logic        speed_reset_key;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  sample_t     audio_sample;
  logic        sample_valid;
  seg_t        hex0;
  seg_t        hex1;
  seg_t        hex2;
  seg_t        hex3;
  seg_t        hex4;
  seg_t        hex5;
  seg_t        shown [6];

  // Test steps from the data file
  logic [7:0]  step_op  [MAX_STEPS];
  logic [31:0] step_arg [MAX_STEPS];
  int          step_total;

  // Reference state of the player
  flash_addr_t model_addr;
  logic        model_backward;
  logic        model_held;
  sample_t     model_held_val;
  int unsigned model_div;

  int          value_errors;
  int          other_errors;
  int          sample_count;
  int unsigned cycle_count;
  int unsigned cycle_limit;
  logic        stall_q;
  flash_addr_t stall_addr;

  simple_ipod_top #(
    .DEFAULT_DIVISOR (DEFAULT_DIV),
    .DIVISOR_STEP    (DIV_STEP),
    .MIN_DIVISOR     (MIN_DIV),
    .MAX_DIVISOR     (MAX_DIV),
    .REPEAT_CYCLES   (REPEAT),
    .LAST_WORD_ADDR  (LAST_ADDR)
  ) dut (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .ascii_code          (ascii_code),
    .ascii_strobe        (ascii_strobe),
    .speed_up_key        (speed_up_key),
    .speed_down_key      (speed_down_key),
    .speed_reset_key     (speed_reset_key),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  flash_model u_flash (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  assign shown[0] = hex0;
  assign shown[1] = hex1;
  assign shown[2] = hex2;
  assign shown[3] = hex3;
  assign shown[4] = hex4;
  assign shown[5] = hex5;

  always #10 CLK_50M = ~CLK_50M;

  // ========================================
  // Reference rules
  // ========================================
  function automatic sample_t word_high(input flash_addr_t addr);
    return addr[15:0] ^ 16'h5A5A;
  endfunction

  function automatic sample_t word_low(input flash_addr_t addr);
    return addr[15:0];
  endfunction

  // Next word address, wrapping between 0 and LAST_ADDR
  function automatic flash_addr_t step_address(input flash_addr_t addr, input logic back);
    flash_addr_t next;
    if (!back)
      next = (addr >= LAST_ADDR) ? '0 : addr + 23'd1;
    else if (addr == '0)
      next = LAST_ADDR;
    else
      next = addr - 23'd1;
    return next;
  endfunction

  function automatic int unsigned step_budget(input logic [7:0] op, input logic [31:0] arg);
    case (op)
      "S": return arg * MAX_DIV * 2;
      "C": return 5;
      "V": return 1;
      default: return arg + 3;
    endcase
  endfunction

  // ========================================
  // Test steps
  // ========================================
  task automatic read_tests();
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    logic [31:0] arg;
    step_total = 0;
    fd = $fopen("simple_ipod_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test file simple_ipod_tests.txt");
      other_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#" && step_total < MAX_STEPS)
        begin
          if ($sscanf(line, "%c %h", op, arg) == 2)
          begin
            step_op[step_total]  = op;
            step_arg[step_total] = arg;
            step_total++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_command(input logic [7:0] code);
    logic [7:0] upper;
    upper = (code >= 8'h61 && code <= 8'h7A) ? code - 8'h20 : code;
    ascii_code   <= code;
    ascii_strobe <= 1'b1;
    @(posedge CLK_50M);
    ascii_strobe <= 1'b0;
    repeat (3) @(posedge CLK_50M);
    case (upper)
      8'h46: model_backward = 1'b0;
      8'h42: model_backward = 1'b1;
      8'h52:
      begin
        // Held half is lost, playback starts over at the end it faces
        model_held = 1'b0;
        model_addr = model_backward ? LAST_ADDR : '0;
      end
      default: ;
    endcase
  endtask

  task automatic check_quiet(input int unsigned cycles, input logic no_reads);
    repeat (cycles)
    begin
      @(posedge CLK_50M);
      if (sample_valid)
      begin
        $display("[FAIL] sample_valid: got %h, expected %h", sample_valid, 1'b0);
        value_errors++;
      end
      if (no_reads && flash_read)
      begin
        $display("[FAIL] flash_read: got %h, expected %h", flash_read, 1'b0);
        value_errors++;
      end
    end
  endtask

  task automatic collect_samples(input int unsigned count);
    int target;
    target = sample_count + count;
    while (sample_count < target)
      @(posedge CLK_50M);
  endtask

  task automatic press_key(input logic [7:0] op, input int unsigned cycles);
    int unsigned steps;
    if (op == "U")
      speed_up_key <= 1'b1;
    else if (op == "D")
      speed_down_key <= 1'b1;
    else
      speed_reset_key <= 1'b1;
    repeat (cycles) @(posedge CLK_50M);
    speed_up_key    <= 1'b0;
    speed_down_key  <= 1'b0;
    speed_reset_key <= 1'b0;
    repeat (2) @(posedge CLK_50M);
    // One step at the press, one more per full repeat interval
    steps = 1 + (cycles - 1) / REPEAT;
    if (op == "Z")
      model_div = DEFAULT_DIV;
    else
    begin
      repeat (steps)
      begin
        if (op == "U")
          model_div = (model_div >= MIN_DIV + DIV_STEP) ? model_div - DIV_STEP : MIN_DIV;
        else
          model_div = (model_div + DIV_STEP <= MAX_DIV) ? model_div + DIV_STEP : MAX_DIV;
      end
    end
  endtask

  task automatic check_display(input logic [31:0] expected);
    divisor_t want;
    int       i;
    if (expected != model_div)
    begin
      $display("Test file expects divisor %h but the speed rules give %h", expected, model_div);
      other_errors++;
    end
    want = divisor_t'(model_div);
    for (i = 0; i < 6; i++)
    begin
      if (shown[i] !== SEG_TABLE[want[4*i +: 4]])
      begin
        $display("[FAIL] hex%0d: got %h, expected %h", i, shown[i], SEG_TABLE[want[4*i +: 4]]);
        value_errors++;
      end
    end
  endtask

  task automatic run_step(input logic [7:0] op, input logic [31:0] arg);
    case (op)
      "C": send_command(arg[7:0]);
      "I": check_quiet(arg, 1'b1);
      "Q": check_quiet(arg, 1'b0);
      "S": collect_samples(arg);
      "U", "D", "Z": press_key(op, arg);
      "V": check_display(arg);
      default:
      begin
        $display("Unknown step code %h in the test file", op);
        other_errors++;
      end
    endcase
  endtask

  // ========================================
  // Sample and flash port monitor
  // ========================================
  always @(posedge CLK_50M)
  begin
    sample_t expected_sample;
    if (rst)
      stall_q = 1'b0;
    else
    begin
      if (stall_q && flash_address !== stall_addr)
      begin
        $display("[FAIL] flash_address: got %h, expected %h", flash_address, stall_addr);
        value_errors++;
      end
      if (flash_read && !flash_waitrequest && flash_address !== model_addr)
      begin
        $display("[FAIL] flash_address: got %h, expected %h", flash_address, model_addr);
        value_errors++;
      end
      if (sample_valid)
      begin
        if (model_held)
        begin
          expected_sample = model_held_val;
          model_held      = 1'b0;
        end
        else
        begin
          // Forward starts a word with the low half, backward with the high half
          expected_sample = model_backward ? word_high(model_addr) : word_low(model_addr);
          model_held_val  = model_backward ? word_low(model_addr) : word_high(model_addr);
          model_held      = 1'b1;
          model_addr      = step_address(model_addr, model_backward);
        end
        if (audio_sample !== expected_sample)
        begin
          $display("[FAIL] audio_sample: got %h, expected %h", audio_sample, expected_sample);
          value_errors++;
        end
        sample_count++;
      end
      stall_q    = flash_read && flash_waitrequest;
      stall_addr = flash_address;
    end
  end

  // Watchdog
  always @(posedge CLK_50M)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    int unsigned limit;
    int          i;
    CLK_50M         = 1'b0;
    rst             = 1'b1;
    ascii_code      = 8'h00;
    ascii_strobe    = 1'b0;
    speed_up_key    = 1'b0;
    speed_down_key  = 1'b0;
    speed_reset_key = 1'b0;
    value_errors    = 0;
    other_errors    = 0;
    sample_count    = 0;
    cycle_count     = 0;
    model_addr      = '0;
    model_backward  = 1'b0;
    model_held      = 1'b0;
    model_held_val  = '0;
    model_div       = DEFAULT_DIV;

    read_tests();
    if (step_total == 0)
    begin
      $display("No test steps were read from the test file");
      other_errors++;
    end
    limit = 2 + MARGIN;
    for (i = 0; i < step_total; i++)
      limit = limit + step_budget(step_op[i], step_arg[i]);
    cycle_limit = limit;

    repeat (2) @(posedge CLK_50M);
    rst <= 1'b0;

    for (i = 0; i < step_total; i++)
      run_step(step_op[i], step_arg[i]);

    repeat (5) @(posedge CLK_50M);
    $display("Error count: %0d value mismatches, %0d other failures, %0d samples checked",
             value_errors, other_errors, sample_count);
    if (value_errors + other_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- list.f
ipod_pkg.sv
key_command_decoder.sv
speed_control.sv
sample_tick_gen.sv
flash_sample_reader.sv
hex_display.sv
simple_ipod_top.sv
flash_model.sv
tb_simple_ipod.sv

//--- Makefile
# Verilator build and run for the sample player testbench

VERILATOR ?= verilator
TOP       ?= tb_simple_ipod
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TESTS     ?= simple_ipod_tests.txt
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SRCS := ipod_pkg.sv key_command_decoder.sv speed_control.sv sample_tick_gen.sv \
        flash_sample_reader.sv hex_display.sv simple_ipod_top.sv \
        flash_model.sv tb_simple_ipod.sv

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f

run: $(BIN) $(TESTS)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- simple_ipod_tests.txt
# Columns: step code, argument in hex
# C command byte, I/Q cycles without samples (I also without reads), S samples, U/D/Z key cycles, V divisor
V 0000C8
I 1F4
C 45
S 28
C 58
S 7
C 44
Q 3E8
C 42
C 52
C 65
S 24
C 44
U 1
V BE
D 1
V C8
U 190
V 78
D A1
V AA
D 3E8
V 190
Z 1
V C8
D 51
V E6
Z 3
V C8
C 46
C 45
S 10
